// File: hdl/rp_pkg.sv
/*
 * analog path package
 * widths, register map, reset values and configuration types
 */

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // data path widths
  ////////////////////////////////////////////////////////////

  // analog channels
  localparam int CHN = 2;
  // ADC pin word, sample sits in bits 15..2
  localparam int ADW = 16;
  // sample width
  localparam int SW = 14;
  // gain width, Q2.14
  localparam int MW = 16;
  localparam int MUL_FRAC = 14;
  // calibration intermediates
  localparam int PRD_W = SW + MW;
  localparam int SHF_W = PRD_W - MUL_FRAC;
  localparam int ACC_W = SHF_W + 1;

  // PDM
  localparam int PDM_CHN = 4;
  localparam int PDM_W = 8;
  localparam logic [PDM_W:0] PDM_RNG = 255;

  // debounce counter
  localparam int DEB_CW = 16;
  // 0.5 ms at 125 MHz
  localparam logic [DEB_CW-1:0] DEB_LEN_RST = 16'd62500;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  localparam int RAW = 4;
  localparam int RDW = 16;

  localparam logic [RAW-1:0] A_ADC_MUL0 = 4'd0;
  localparam logic [RAW-1:0] A_ADC_MUL1 = 4'd1;
  localparam logic [RAW-1:0] A_ADC_SUM0 = 4'd2;
  localparam logic [RAW-1:0] A_ADC_SUM1 = 4'd3;
  localparam logic [RAW-1:0] A_DAC_MUL0 = 4'd4;
  localparam logic [RAW-1:0] A_DAC_MUL1 = 4'd5;
  localparam logic [RAW-1:0] A_DAC_SUM0 = 4'd6;
  localparam logic [RAW-1:0] A_DAC_SUM1 = 4'd7;
  localparam logic [RAW-1:0] A_LOOP     = 4'd8;
  localparam logic [RAW-1:0] A_PDM0     = 4'd9;
  localparam logic [RAW-1:0] A_PDM1     = 4'd10;
  localparam logic [RAW-1:0] A_PDM2     = 4'd11;
  localparam logic [RAW-1:0] A_PDM3     = 4'd12;
  localparam logic [RAW-1:0] A_DEB_LEN  = 4'd13;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [SW-1:0] smp_t;
  typedef logic [PDM_W-1:0] pdm_val_t;

  // gain and offset for one calibration stage
  typedef struct packed {
    logic signed [MW-1:0] mul;
    logic signed [SW-1:0] sum;
  } cal_cfg_t;

  // unity gain, no offset
  localparam logic signed [MW-1:0] GAIN_RST = 16'sd16384;
  localparam cal_cfg_t CAL_RST = '{mul: GAIN_RST, sum: '0};

endpackage

// File: hdl/rp_regs.sv
/*
 * configuration registers
 * strobe write, combinational read-back
 */

`timescale 1ns/10ps

module rp_regs
  import rp_pkg::*;
(
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // register port
  input  logic                        reg_we_i,
  input  logic [RAW-1:0]              reg_addr_i,
  input  logic [RDW-1:0]              reg_wdata_i,
  output logic [RDW-1:0]              reg_rdata_o,
  // configuration outputs
  output cal_cfg_t [CHN-1:0]          adc_cal_o,
  output cal_cfg_t [CHN-1:0]          dac_cal_o,
  output logic [CHN-1:0]              loop_o,
  output pdm_val_t [PDM_CHN-1:0]      pdm_o,
  output logic [DEB_CW-1:0]           deb_len_o
);

  // write decode
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_cal_o <= {CHN{CAL_RST}};
      dac_cal_o <= {CHN{CAL_RST}};
      loop_o    <= '0;
      pdm_o     <= '0;
      deb_len_o <= DEB_LEN_RST;
    end else if (reg_we_i) begin
      // narrow fields take the low bits
      case (reg_addr_i)
        A_ADC_MUL0: adc_cal_o[0].mul <= reg_wdata_i[MW-1:0];
        A_ADC_MUL1: adc_cal_o[1].mul <= reg_wdata_i[MW-1:0];
        A_ADC_SUM0: adc_cal_o[0].sum <= reg_wdata_i[SW-1:0];
        A_ADC_SUM1: adc_cal_o[1].sum <= reg_wdata_i[SW-1:0];
        A_DAC_MUL0: dac_cal_o[0].mul <= reg_wdata_i[MW-1:0];
        A_DAC_MUL1: dac_cal_o[1].mul <= reg_wdata_i[MW-1:0];
        A_DAC_SUM0: dac_cal_o[0].sum <= reg_wdata_i[SW-1:0];
        A_DAC_SUM1: dac_cal_o[1].sum <= reg_wdata_i[SW-1:0];
        A_LOOP:     loop_o           <= reg_wdata_i[CHN-1:0];
        A_PDM0:     pdm_o[0]         <= reg_wdata_i[PDM_W-1:0];
        A_PDM1:     pdm_o[1]         <= reg_wdata_i[PDM_W-1:0];
        A_PDM2:     pdm_o[2]         <= reg_wdata_i[PDM_W-1:0];
        A_PDM3:     pdm_o[3]         <= reg_wdata_i[PDM_W-1:0];
        A_DEB_LEN:  deb_len_o        <= reg_wdata_i[DEB_CW-1:0];
        // unmapped addresses
        default: ;
      endcase
    end
  end

  // read-back, offsets sign extended, the rest zero extended
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      A_ADC_MUL0: reg_rdata_o = adc_cal_o[0].mul;
      A_ADC_MUL1: reg_rdata_o = adc_cal_o[1].mul;
      A_ADC_SUM0: reg_rdata_o = RDW'(adc_cal_o[0].sum);
      A_ADC_SUM1: reg_rdata_o = RDW'(adc_cal_o[1].sum);
      A_DAC_MUL0: reg_rdata_o = dac_cal_o[0].mul;
      A_DAC_MUL1: reg_rdata_o = dac_cal_o[1].mul;
      A_DAC_SUM0: reg_rdata_o = RDW'(dac_cal_o[0].sum);
      A_DAC_SUM1: reg_rdata_o = RDW'(dac_cal_o[1].sum);
      A_LOOP:     reg_rdata_o = RDW'(loop_o);
      A_PDM0:     reg_rdata_o = RDW'(pdm_o[0]);
      A_PDM1:     reg_rdata_o = RDW'(pdm_o[1]);
      A_PDM2:     reg_rdata_o = RDW'(pdm_o[2]);
      A_PDM3:     reg_rdata_o = RDW'(pdm_o[3]);
      A_DEB_LEN:  reg_rdata_o = RDW'(deb_len_o);
      default: ;
    endcase
  end

endmodule

// File: hdl/adc_front.sv
/*
 * ADC front end for one channel
 * pin capture, code conversion and digital loopback select
 */

`timescale 1ns/10ps

module adc_front
  import rp_pkg::*;
(
  input  logic           adc_clk,
  // converter pins
  input  logic [ADW-1:0] adc_dat_i,
  // loopback control
  input  logic           loop_i,
  // calibrated DAC sample
  input  smp_t           dac_smp_i,
  output smp_t           smp_o
);

  // captured sample
  smp_t adc_raw;

  // IO register, lowest 2 bits unused by the 14 bit converter
  // converter code is inverted except the sign
  always_ff @(posedge adc_clk) begin
    adc_raw <= {adc_dat_i[ADW-1], ~adc_dat_i[ADW-2:ADW-SW]};
  end

  // loopback bypasses the capture register
  assign smp_o = loop_i ? dac_smp_i : adc_raw;

endmodule

// File: hdl/lin_cal.sv
/*
 * linear calibration, one channel
 * gain in Q2.14, offset add and saturation in one stage
 */

`timescale 1ns/10ps

module lin_cal
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     top_rst,
  input  smp_t     smp_i,
  input  cal_cfg_t cfg_i,
  output smp_t     smp_o
);

  // full product
  logic signed [PRD_W-1:0] prd;
  // product after the Q2.14 shift
  logic signed [SHF_W-1:0] shf;
  // one guard bit for the offset add
  logic signed [ACC_W-1:0] acc;
  smp_t                    sat;

  always_comb begin
    prd = smp_i * cfg_i.mul;
    // arithmetic shift by dropping fraction bits
    shf = prd[PRD_W-1:MUL_FRAC];
    acc = ACC_W'(shf) + ACC_W'(cfg_i.sum);
    // in range when all bits above the sample sign agree
    if (acc[ACC_W-1:SW-1] == '0 || acc[ACC_W-1:SW-1] == '1) begin
      sat = acc[SW-1:0];
    end else if (acc[ACC_W-1]) begin
      // negative full scale
      sat = {1'b1, {(SW-1){1'b0}}};
    end else begin
      // positive full scale
      sat = {1'b0, {(SW-1){1'b1}}};
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

endmodule

// File: hdl/pdm_mod.sv
/*
 * pulse density modulator
 * first order, one accumulator per channel, period 255
 */

`timescale 1ns/10ps

module pdm_mod
  import rp_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  pdm_val_t [PDM_CHN-1:0] val_i,
  output logic [PDM_CHN-1:0]     pdm_o
);

  // one extra bit, sum stays below 2*255
  logic [PDM_CHN-1:0][PDM_W:0] acc;
  logic [PDM_CHN-1:0][PDM_W:0] nxt;

  for (genvar i = 0; i < PDM_CHN; i++) begin : g_chn

    assign nxt[i] = acc[i] + {1'b0, val_i[i]};

    // overflow of the period gives a one
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc[i]   <= '0;
        pdm_o[i] <= 1'b0;
      end else if (nxt[i] >= PDM_RNG) begin
        acc[i]   <= nxt[i] - PDM_RNG;
        pdm_o[i] <= 1'b1;
      end else begin
        acc[i]   <= nxt[i];
        pdm_o[i] <= 1'b0;
      end
    end

  end

endmodule

// File: hdl/debounce.sv
/*
 * input debounce
 * two flop synchronizer, lockout counter, edge pulses
 */

`timescale 1ns/10ps

module debounce
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              top_rst,
  // asynchronous input
  input  logic              d_i,
  // lockout length in cycles
  input  logic [DEB_CW-1:0] len_i,
  output logic              pos_o,
  output logic              neg_o
);

  // synchronizer stages
  logic              d_s1;
  logic              d_s2;
  // accepted level
  logic              stb;
  // lockout countdown
  logic [DEB_CW-1:0] cnt;
  logic              acc;

  // new level, lockout expired
  assign acc = (d_s2 != stb) && (cnt == '0);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      d_s1  <= 1'b0;
      d_s2  <= 1'b0;
      stb   <= 1'b0;
      cnt   <= '0;
      pos_o <= 1'b0;
      neg_o <= 1'b0;
    end else begin
      d_s1  <= d_i;
      d_s2  <= d_s1;
      pos_o <= acc & d_s2;
      neg_o <= acc & ~d_s2;
      if (acc) begin
        stb <= d_s2;
        cnt <= len_i;
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

// File: hdl/rp_top.sv
/*
 * analog path top level
 * two ADC and DAC channels with calibration and loopback,
 * PDM outputs and expansion input debounce
 */

`timescale 1ns/10ps

module rp_top
  import rp_pkg::*;
(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // ADC pins
  input  logic [CHN-1:0][ADW-1:0]   adc_dat_i,
  // DAC samples
  input  smp_t [CHN-1:0]            dac_smp_i,
  // register port
  input  logic                      reg_we_i,
  input  logic [RAW-1:0]            reg_addr_i,
  input  logic [RDW-1:0]            reg_wdata_i,
  output logic [RDW-1:0]            reg_rdata_o,
  // calibrated acquisition
  output smp_t [CHN-1:0]            osc_dat_o,
  // DAC pins, one word per channel
  output logic [CHN-1:0][SW-1:0]    dac_dat_o,
  // PDM outputs
  output logic [PDM_CHN-1:0]        dac_pwm_o,
  // expansion input and triggers
  input  logic                      exp_i,
  output logic                      trg_pos_o,
  output logic                      trg_neg_o,
  // clock duty cycle stabilizer
  output logic                      adc_cdcs_o
);

  // configuration
  cal_cfg_t [CHN-1:0]     adc_cal;
  cal_cfg_t [CHN-1:0]     dac_cal;
  logic [CHN-1:0]         loop;
  pdm_val_t [PDM_CHN-1:0] pdm_val;
  logic [DEB_CW-1:0]      deb_len;

  // samples between stages
  smp_t [CHN-1:0]         adc_smp;
  smp_t [CHN-1:0]         dac_cal_smp;

  // stabilizer always on
  assign adc_cdcs_o = 1'b1;

  rp_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .adc_cal_o   (adc_cal),
    .dac_cal_o   (dac_cal),
    .loop_o      (loop),
    .pdm_o       (pdm_val),
    .deb_len_o   (deb_len)
  );

  ////////////////////////////////////////////////////////////
  // analog channels
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CHN; i++) begin : g_chn

    // capture and loopback select
    adc_front u_adc_front (
      .adc_clk   (adc_clk),
      .adc_dat_i (adc_dat_i[i]),
      .loop_i    (loop[i]),
      .dac_smp_i (dac_cal_smp[i]),
      .smp_o     (adc_smp[i])
    );

    // acquisition side calibration
    lin_cal u_adc_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (adc_smp[i]),
      .cfg_i   (adc_cal[i]),
      .smp_o   (osc_dat_o[i])
    );

    // generation side calibration
    lin_cal u_dac_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (dac_smp_i[i]),
      .cfg_i   (dac_cal[i]),
      .smp_o   (dac_cal_smp[i])
    );

    // DAC output register
    // two's complement to inverted offset code
    always_ff @(posedge adc_clk) begin
      dac_dat_o[i] <= {dac_cal_smp[i][SW-1], ~dac_cal_smp[i][SW-2:0]};
    end

  end

  ////////////////////////////////////////////////////////////
  // PDM and expansion input
  ////////////////////////////////////////////////////////////

  pdm_mod u_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .val_i   (pdm_val),
    .pdm_o   (dac_pwm_o)
  );

  debounce u_debounce (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .d_i     (exp_i),
    .len_i   (deb_len),
    .pos_o   (trg_pos_o),
    .neg_o   (trg_neg_o)
  );

endmodule

// File: tb/tb_rp_top.sv
/*
 * testbench for the analog path top level
 * random stimulus, reference model, per test report
 */

`timescale 1ns/10ps

module tb_rp_top
  import rp_pkg::*;
();

  // cycle budgets per test, used by the watchdog
  localparam int BUD_REGS = 300;
  localparam int BUD_ADC  = 600;
  localparam int BUD_DAC  = 600;
  localparam int BUD_LOOP = 800;
  localparam int BUD_PDM  = 1400;
  localparam int BUD_DEB  = 2000;
  localparam int RUN_NS   = (BUD_REGS + BUD_ADC + BUD_DAC + BUD_LOOP + BUD_PDM + BUD_DEB) * 10
                            + 2000;

  // expected outputs of one sample slot
  typedef struct packed {
    smp_t [CHN-1:0]         osc;
    logic [CHN-1:0][SW-1:0] dac;
  } path_exp_t;

  logic                    adc_clk;
  logic                    top_rst;
  logic [CHN-1:0][ADW-1:0] adc_dat_i;
  smp_t [CHN-1:0]          dac_smp_i;
  logic                    reg_we_i;
  logic [RAW-1:0]          reg_addr_i;
  logic [RDW-1:0]          reg_wdata_i;
  logic [RDW-1:0]          reg_rdata_o;
  smp_t [CHN-1:0]          osc_dat_o;
  logic [CHN-1:0][SW-1:0]  dac_dat_o;
  logic [PDM_CHN-1:0]      dac_pwm_o;
  logic                    exp_i;
  logic                    trg_pos_o;
  logic                    trg_neg_o;
  logic                    adc_cdcs_o;

  // register shadow, held in read-back form
  logic [RDW-1:0] shadow [0:15];
  path_exp_t      exp_q[$];
  // debounce model state
  logic           m_s1;
  logic           m_s2;
  logic           m_stb;
  logic           m_pos;
  logic           m_neg;
  int             m_cnt;
  int             m_len;
  int             m_pulses;
  // pulses seen on the DUT trigger outputs
  int             trg_seen;
  // bookkeeping
  int             rnd_seed;
  int             err_cnt;
  int             test_err;
  int             test_cnt;
  int             test_fail;
  int             chk_cnt;

  rp_top dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .dac_smp_i   (dac_smp_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .osc_dat_o   (osc_dat_o),
    .dac_dat_o   (dac_dat_o),
    .dac_pwm_o   (dac_pwm_o),
    .exp_i       (exp_i),
    .trg_pos_o   (trg_pos_o),
    .trg_neg_o   (trg_neg_o),
    .adc_cdcs_o  (adc_cdcs_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // gain in Q2.14, offset, clamp to 14 bit range
  function automatic smp_t calibrate(smp_t s, logic [RDW-1:0] mul, logic [RDW-1:0] sum);
    longint res;
    res = (longint'(s) * longint'($signed(mul))) >>> 14;
    res = res + longint'($signed(sum));
    if (res > 8191) begin
      res = 8191;
    end else if (res < -8192) begin
      res = -8192;
    end
    return res[SW-1:0];
  endfunction

  // converter code has all but the sign inverted
  // mask covers the 13 magnitude bits
  function automatic smp_t adc_code_to_smp(logic [ADW-1:0] w);
    return w[ADW-1:ADW-SW] ^ 14'h1fff;
  endfunction

  function automatic logic [SW-1:0] smp_to_dac_code(smp_t s);
    return s ^ 14'h1fff;
  endfunction

  function automatic void reset_shadow();
    for (int a = 0; a < 16; a++) begin
      shadow[a] = '0;
    end
    shadow[A_ADC_MUL0] = 16'h4000;
    shadow[A_ADC_MUL1] = 16'h4000;
    shadow[A_DAC_MUL0] = 16'h4000;
    shadow[A_DAC_MUL1] = 16'h4000;
    shadow[A_DEB_LEN]  = 16'd62500;
  endfunction

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[ERROR] %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    err_cnt++;
    test_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("[ERROR] %s at %0t", msg, $time);
    err_cnt++;
    test_err++;
  endtask

  task automatic start_test();
    test_err = 0;
    test_cnt++;
  endtask

  task automatic finish_test(input string name);
    if (test_err != 0) begin
      test_fail++;
    end
    $display("[%s] %s, %0d errors", name, (test_err == 0) ? "pass" : "fail", test_err);
  endtask

  ////////////////////////////////////////////////////////////
  // bus and path helpers
  ////////////////////////////////////////////////////////////

  // one cycle strobe, shadow follows the field rules
  task automatic write_reg(input logic [RAW-1:0] addr, input logic [RDW-1:0] data);
    @(negedge adc_clk);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge adc_clk);
    reg_we_i = 1'b0;
    case (addr)
      A_ADC_SUM0, A_ADC_SUM1, A_DAC_SUM0, A_DAC_SUM1: shadow[addr] = {{2{data[13]}}, data[13:0]};
      A_LOOP: shadow[addr] = {14'd0, data[1:0]};
      A_PDM0, A_PDM1, A_PDM2, A_PDM3: shadow[addr] = {8'd0, data[7:0]};
      4'd14, 4'd15: ;
      default: shadow[addr] = data;
    endcase
  endtask

  task automatic read_check(input logic [RAW-1:0] addr);
    @(negedge adc_clk);
    reg_addr_i = addr;
    @(negedge adc_clk);
    chk_cnt++;
    if (reg_rdata_o !== shadow[addr]) begin
      report_mismatch($sformatf("reg_rdata_o[%0d]", addr), 32'(shadow[addr]), 32'(reg_rdata_o));
    end
  endtask

  // random gain and offset for both channels, base is the channel 0 gain
  task automatic rand_cal(input logic [RAW-1:0] base);
    for (int k = 0; k < 4; k++) begin
      write_reg(RAW'(base + k), RDW'($urandom));
    end
  endtask

  // random samples each cycle, outputs checked two cycles later
  task automatic run_path(input int cycles);
    path_exp_t e;
    smp_t      dcal;
    smp_t      src;
    exp_q.delete();
    for (int n = 0; n < cycles + 2; n++) begin
      @(negedge adc_clk);
      if (n >= 2) begin
        e = exp_q.pop_front();
        for (int c = 0; c < CHN; c++) begin
          chk_cnt += 2;
          if (osc_dat_o[c] !== e.osc[c]) begin
            report_mismatch($sformatf("osc_dat_o[%0d]", c), 32'(e.osc[c]), 32'(osc_dat_o[c]));
          end
          if (dac_dat_o[c] !== e.dac[c]) begin
            report_mismatch($sformatf("dac_dat_o[%0d]", c), 32'(e.dac[c]), 32'(dac_dat_o[c]));
          end
        end
      end
      if (n < cycles) begin
        for (int c = 0; c < CHN; c++) begin
          adc_dat_i[c] = ADW'($urandom);
          dac_smp_i[c] = smp_t'($urandom);
          dcal = calibrate(dac_smp_i[c], shadow[A_DAC_MUL0 + c], shadow[A_DAC_SUM0 + c]);
          // loopback takes the calibrated DAC sample
          src = shadow[A_LOOP][c] ? dcal : adc_code_to_smp(adc_dat_i[c]);
          e.osc[c] = calibrate(src, shadow[A_ADC_MUL0 + c], shadow[A_ADC_SUM0 + c]);
          e.dac[c] = smp_to_dac_code(dcal);
        end
        exp_q.push_back(e);
      end
    end
  endtask

  // one cycle of the expansion input, model steps to the next edge
  task automatic deb_cycle(input logic d);
    logic hit;
    @(negedge adc_clk);
    chk_cnt += 2;
    if (trg_pos_o !== m_pos) begin
      report_mismatch("trg_pos_o", 32'(m_pos), 32'(trg_pos_o));
    end
    if (trg_neg_o !== m_neg) begin
      report_mismatch("trg_neg_o", 32'(m_neg), 32'(trg_neg_o));
    end
    if (trg_pos_o === 1'b1 || trg_neg_o === 1'b1) begin
      trg_seen++;
    end
    exp_i = d;
    // level change accepted only outside the lockout
    hit   = (m_s2 != m_stb) && (m_cnt == 0);
    m_pos = hit && m_s2;
    m_neg = hit && !m_s2;
    if (hit) begin
      m_stb = m_s2;
      m_cnt = m_len;
      m_pulses++;
    end else if (m_cnt != 0) begin
      m_cnt--;
    end
    // two flop synchronizer delay
    m_s2 = m_s1;
    m_s1 = d;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          ones [PDM_CHN];
    logic [7:0]  val;
    logic [3:0]  addr;
    rnd_seed    = $urandom(40);
    err_cnt     = 0;
    test_cnt    = 0;
    test_fail   = 0;
    chk_cnt     = 0;
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    dac_smp_i   = '0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    exp_i       = 1'b0;
    reset_shadow();
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;

    // reset values, then random writes
    start_test();
    // stabilizer pin is tied high
    chk_cnt++;
    if (adc_cdcs_o !== 1'b1) begin
      report_mismatch("adc_cdcs_o", 32'h1, 32'(adc_cdcs_o));
    end
    for (int a = 0; a < 16; a++) begin
      read_check(RAW'(a));
    end
    repeat (40) begin
      addr = RAW'($urandom_range(0, 15));
      write_reg(addr, RDW'($urandom));
      read_check(addr);
    end
    for (int a = 0; a < 16; a++) begin
      read_check(RAW'(a));
    end
    finish_test("regs");

    // acquisition path, loopback off
    start_test();
    write_reg(A_LOOP, '0);
    for (int r = 0; r < 6; r++) begin
      rand_cal(A_ADC_MUL0);
      run_path(64);
    end
    finish_test("adc_path");

    // generation path
    start_test();
    for (int r = 0; r < 6; r++) begin
      rand_cal(A_DAC_MUL0);
      run_path(64);
    end
    finish_test("dac_path");

    // loopback on one channel at a time
    start_test();
    for (int ch = 0; ch < CHN; ch++) begin
      write_reg(A_LOOP, RDW'(1 << ch));
      for (int r = 0; r < 3; r++) begin
        rand_cal(A_ADC_MUL0);
        rand_cal(A_DAC_MUL0);
        run_path(64);
      end
    end
    write_reg(A_LOOP, '0);
    finish_test("loopback");

    // ones per period equal the value, 0 and 255 forced in the first rounds
    start_test();
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < PDM_CHN; c++) begin
        val = 8'($urandom);
        if (r == 0 && c == 0 || r == 1 && c == 3) begin
          val = 8'd0;
        end else if (r == 0 && c == 1 || r == 1 && c == 2) begin
          val = 8'd255;
        end
        write_reg(RAW'(A_PDM0 + c), {8'd0, val});
      end
      repeat (3) @(negedge adc_clk);
      for (int c = 0; c < PDM_CHN; c++) begin
        ones[c] = 0;
      end
      repeat (PDM_RNG) begin
        @(negedge adc_clk);
        for (int c = 0; c < PDM_CHN; c++) begin
          ones[c] += int'(dac_pwm_o[c]);
        end
      end
      for (int c = 0; c < PDM_CHN; c++) begin
        chk_cnt++;
        if (ones[c] != int'(shadow[A_PDM0 + c])) begin
          report_mismatch($sformatf("dac_pwm_o[%0d] ones", c), 32'(shadow[A_PDM0 + c]),
                          32'(ones[c]));
        end
      end
    end
    finish_test("pdm");

    // short lockout, toggles with random gaps
    start_test();
    m_len = $urandom_range(12, 24);
    write_reg(A_DEB_LEN, RDW'(m_len));
    m_s1     = 1'b0;
    m_s2     = 1'b0;
    m_stb    = 1'b0;
    m_pos    = 1'b0;
    m_neg    = 1'b0;
    m_cnt    = 0;
    m_pulses = 0;
    trg_seen = 0;
    repeat (40) begin
      val = 8'($urandom_range(1, 40));
      repeat (val) deb_cycle(exp_i);
      deb_cycle(~exp_i);
    end
    repeat (m_len + 8) deb_cycle(exp_i);
    chk_cnt++;
    if (trg_seen != m_pulses) begin
      report_mismatch("trigger pulse count", 32'(m_pulses), 32'(trg_seen));
    end
    finish_test("debounce");

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(RUN_NS);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

// File: src.f
hdl/rp_pkg.sv
hdl/rp_regs.sv
hdl/adc_front.sv
hdl/lin_cal.sv
hdl/pdm_mod.sv
hdl/debounce.sv
hdl/rp_top.sv
tb/tb_rp_top.sv

// File: Makefile
TOOL       = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = tb_rp_top
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
